//--- Makefile
# Verilator build and run of the array heap testbench

SIM = obj_dir/VarrayHeapTb

.PHONY: all build lint clean

all: build
	./$(SIM) | tee /dev/stderr | grep -q "^Everything OK$$"

build:
	verilator --binary --assert --top-module arrayHeapTb -f compile.f -o VarrayHeapTb

lint:
	verilator --lint-only --timing --assert --top-module arrayHeapTb -f compile.f

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+testbench
verilog/heapPkg.sv
verilog/heapInterfaces.sv
verilog/requestPort.sv
verilog/heapCheck.sv
verilog/elementStore.sv
verilog/arrayHeap.sv
testbench/arrayHeap_properties.sv
testbench/arrayHeapTb.sv

//--- testbench/heapModel.svh
// Reference model of the array heap
// Model state, clearModel and heapPredict for the expected out and error

`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

bit                  modelAllocated [ArrayCount];  // Live arrays
int                  modelSize      [ArrayCount];
int                  modelStack     [ArrayCount];  // Freed arrays, latest on top
int                  modelTop;
int                  modelFresh;                   // Next never used array
logic [DataBits-1:0] modelMemory    [ArrayCount][ArrayLength];

task automatic clearModel();
  for (int a = 0; a < ArrayCount; a++) begin
    modelAllocated[a] = 1'b0;
    modelSize[a]      = 0;
  end
  modelTop   = 0;
  modelFresh = 0;
endtask

function automatic void heapPredict(
  input  heapAction_t         act,
  input  int                  arr,
  input  int                  idx,
  input  logic [DataBits-1:0] data,
  output logic [DataBits-1:0] predOut,
  output heapError_t          predError
);
  int pick;
  predOut   = '0;  // Any error answers zero
  predError = errNone;
  pick      = -1;
  if (act == actAlloc) begin
    if (modelTop > 0) begin
      modelTop--;
      pick = modelStack[modelTop];  // Most recently freed first
    end else if (modelFresh < ArrayCount) begin
      pick = modelFresh;
      modelFresh++;
    end else begin
      predError = errOutOfMemory;
    end
    if (pick >= 0) begin
      modelAllocated[pick] = 1'b1;
      modelSize[pick]      = 0;  // Starts empty
      predOut              = DataBits'(pick);
    end
  end else if (!modelAllocated[arr]) begin
    predError = errNotAllocated;  // Also a second free
  end else begin
    case (act)
      actFree: begin
        modelAllocated[arr]  = 1'b0;
        modelStack[modelTop] = arr;
        modelTop++;
      end
      actWrite: begin
        if (idx > modelSize[arr]) predError = errOutOfBounds;  // No gaps
        else begin
          modelMemory[arr][idx] = data;
          if (idx == modelSize[arr]) modelSize[arr]++;
          predOut = data;
        end
      end
      actRead, actAdd: begin
        if (idx >= modelSize[arr]) predError = errOutOfBounds;
        else begin
          if (act == actAdd) modelMemory[arr][idx] = modelMemory[arr][idx] + data;  // Wraps
          predOut = modelMemory[arr][idx];
        end
      end
      actSize: predOut = DataBits'(modelSize[arr]);
      actPush: begin
        if (modelSize[arr] == ArrayLength) predError = errFull;
        else begin
          modelMemory[arr][modelSize[arr]] = data;
          modelSize[arr]++;
          predOut = data;
        end
      end
      actPop: begin
        if (modelSize[arr] == 0) predError = errEmpty;
        else begin
          modelSize[arr]--;
          predOut = modelMemory[arr][modelSize[arr]];  // Last in first out
        end
      end
      default: predOut = '0;
    endcase
  end
endfunction

`endif

//--- testbench/arrayHeapTb.sv
// Testbench for the array heap
// Clock, reset, directed and random transactions, comparison process and watchdog

module arrayHeapTb;
  import heapPkg::*;

  localparam int ArrayBits      = defaultArrayBits;
  localparam int IndexBits      = defaultIndexBits;
  localparam int DataBits       = defaultDataBits;
  localparam int ArrayCount     = 1 << ArrayBits;
  localparam int ArrayLength    = 1 << IndexBits;
  localparam int DirectedCount  = 45;  // Directed transactions below
  localparam int RandomCount    = 400;
  localparam int WatchdogCycles = (DirectedCount + RandomCount) * 12 + 100;

  logic                 clock;
  logic                 resetN;
  logic                 req;
  logic                 ack;
  heapAction_t          action;
  logic [ArrayBits-1:0] array;
  logic [IndexBits-1:0] index;
  logic [DataBits-1:0]  in;
  logic [DataBits-1:0]  out;
  heapError_t           error;

  integer seed           = 32'hc655;  // $random state
  int     issuedCount    = 0;
  int     checkedCount   = 0;
  int     outMismatches  = 0;
  int     codeMismatches = 0;
  event   resultReady;

  string               testNames   [$];  // One entry per finished transaction
  logic [DataBits-1:0] expectOut   [$];
  heapError_t          expectError [$];
  logic [DataBits-1:0] gotOut      [$];
  heapError_t          gotError    [$];

  `include "heapModel.svh"

  arrayHeap arrayHeap_i (
    .clock, .resetN, .req, .ack, .action, .array, .index, .in, .out, .error
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ----------------------------------------
  // One four-phase transaction
  // ----------------------------------------
  task automatic runTransaction(input string name, input heapAction_t act, input int arr,
                                input int idx, input logic [DataBits-1:0] data);
    logic [DataBits-1:0] predOut;
    heapError_t          predError;
    @(negedge clock);
    action = act;
    array  = ArrayBits'(arr);
    index  = IndexBits'(idx);
    in     = data;
    req    = 1'b1;
    heapPredict(act, arr, idx, data, predOut, predError);
    issuedCount++;
    while (!ack) @(negedge clock);  // out and error valid with ack
    testNames.push_back(name);
    expectOut.push_back(predOut);
    expectError.push_back(predError);
    gotOut.push_back(out);
    gotError.push_back(error);
    -> resultReady;
    req = 1'b0;
    while (ack) @(negedge clock);  // Release phase
  endtask

  // ----------------------------------------
  // Comparison
  // ----------------------------------------
  initial begin : compareResults
    string               name;
    logic [DataBits-1:0] wantOut;
    logic [DataBits-1:0] haveOut;
    heapError_t          wantError;
    heapError_t          haveError;
    forever begin
      @(resultReady);
      while (gotOut.size() > 0) begin
        name      = testNames.pop_front();
        wantOut   = expectOut.pop_front();
        wantError = expectError.pop_front();
        haveOut   = gotOut.pop_front();
        haveError = gotError.pop_front();
        checkedCount++;
        assert (haveOut == wantOut) else begin
          outMismatches++;
          $display("FAIL %s out expected %h actual %h", name, wantOut, haveOut);
        end
        assert (haveError == wantError) else begin
          codeMismatches++;
          $display("FAIL %s error expected %s actual %s", name, wantError.name(),
                   haveError.name());
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, a transaction never finished",
             WatchdogCycles);
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    heapAction_t         randomAction;
    int                  randomArray;
    int                  randomIndex;
    logic [DataBits-1:0] randomData;
    int                  handshakeErrors;
    resetN = 1'b0;
    req    = 1'b0;
    action = actAlloc;
    array  = '0;
    index  = '0;
    in     = '0;
    clearModel();
    repeat (10) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    runTransaction("read never allocated", actRead, 2, 0, '0);
    runTransaction("size never allocated", actSize, 3, 0, '0);

    for (int i = 0; i < ArrayCount; i++) begin
      runTransaction($sformatf("alloc %0d", i), actAlloc, 0, 0, '0);  // Fresh arrays in order
    end
    runTransaction("alloc out of memory", actAlloc, 0, 0, '0);
    runTransaction("free 2", actFree, 2, 0, '0);
    runTransaction("free 1", actFree, 1, 0, '0);
    runTransaction("realloc freed 1", actAlloc, 0, 0, '0);
    runTransaction("realloc freed 2", actAlloc, 0, 0, '0);

    runTransaction("write 0", actWrite, 0, 0, 16'h1111);
    runTransaction("write 1", actWrite, 0, 1, 16'hfff0);
    runTransaction("write 2", actWrite, 0, 2, 16'h3333);
    runTransaction("size 3", actSize, 0, 0, '0);
    for (int i = 0; i < 3; i++) begin
      runTransaction($sformatf("read %0d", i), actRead, 0, i, '0);
    end
    runTransaction("read past size", actRead, 0, 3, '0);
    runTransaction("write with gap", actWrite, 0, 4, 16'h4444);
    runTransaction("size unchanged", actSize, 0, 0, '0);

    // Array 1 is empty after its reallocation
    for (int i = 0; i <= ArrayLength; i++) begin
      runTransaction($sformatf("push %0d", i), actPush, 1, 0, DataBits'(16'h0100 + i));
    end
    for (int i = 0; i <= ArrayLength; i++) begin
      runTransaction($sformatf("pop %0d", i), actPop, 1, 0, '0);
    end

    runTransaction("add wraps", actAdd, 0, 1, 16'h0020);
    runTransaction("read after add", actRead, 0, 1, '0);

    runTransaction("free 3", actFree, 3, 0, '0);
    runTransaction("read freed", actRead, 3, 0, '0);
    runTransaction("double free", actFree, 3, 0, '0);
    runTransaction("write freed", actWrite, 3, 0, 16'h5555);

    for (int i = 0; i < RandomCount; i++) begin
      randomAction = heapAction_t'(4'($random(seed) & 7));
      randomArray  = $random(seed) & (ArrayCount - 1);
      randomIndex  = $random(seed) & (ArrayLength - 1);
      randomData   = DataBits'($random(seed));
      runTransaction($sformatf("random %0d", i), randomAction, randomArray, randomIndex,
                     randomData);
    end

    repeat (4) @(negedge clock);  // Let the comparison drain
    handshakeErrors = arrayHeap_i.arrayHeapProperties_i.handshakeErrors;
    $display("Issued %0d, checked %0d, mismatches out %0d error %0d, handshake failures %0d",
             issuedCount, checkedCount, outMismatches, codeMismatches, handshakeErrors);
    if (checkedCount != issuedCount) $display("Some transactions were never compared");
    if (outMismatches == 0 && codeMismatches == 0 && checkedCount == issuedCount &&
        handshakeErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- testbench/arrayHeap_properties.sv
// Handshake properties of the array heap
// Bound into arrayHeap

module arrayHeap_properties #(
  parameter int DataBits = heapPkg::defaultDataBits
) (
  input logic                clock,
  input logic                resetN,
  input logic                req,
  input logic                ack,
  input logic [DataBits-1:0] out,
  input heapPkg::heapError_t error
);

  int handshakeErrors = 0;  // Failed handshake checks

  ackRiseNeedsReq: assert property (@(posedge clock) disable iff (!resetN)
    $rose(ack) |-> $past(req))
    else begin
      handshakeErrors++;
      $error("ack rose while req was low");
    end

  ackFallNeedsRelease: assert property (@(posedge clock) disable iff (!resetN)
    $fell(ack) |-> !$past(req))
    else begin
      handshakeErrors++;
      $error("ack fell while req was still high");
    end

  ackLowInReset: assert property (@(posedge clock) !resetN |-> !ack)
    else begin
      handshakeErrors++;
      $error("ack high during reset");
    end

  resultHeld: assert property (@(posedge clock) disable iff (!resetN)
    ack && $past(ack) |-> $stable(out) && $stable(error))
    else begin
      handshakeErrors++;
      $error("out or error changed while ack was high");
    end

endmodule

bind arrayHeap arrayHeap_properties #(.DataBits(DataBits)) arrayHeapProperties_i (
  .clock, .resetN, .req, .ack, .out, .error
);

//--- verilog/arrayHeap.sv
// Top level of the array heap
// Request port, checker and element store in a three stage pipeline

module arrayHeap #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 req,     // Four-phase request
  output logic                 ack,     // Four-phase acknowledge
  input  heapPkg::heapAction_t action,
  input  logic [ArrayBits-1:0] array,
  input  logic [IndexBits-1:0] index,
  input  logic [DataBits-1:0]  in,
  output logic [DataBits-1:0]  out,
  output heapPkg::heapError_t  error
);
  import heapPkg::*;

  logic                resultValid;  // Element store back to request port
  logic [DataBits-1:0] resultValue;
  heapError_t          resultError;

  // ----------------------------------------
  // Stage links
  // ----------------------------------------
  heapRequestIf #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits))
    heapRequest_i ();
  heapAccessIf #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits))
    heapAccess_i ();

  // ----------------------------------------
  // Stages
  // ----------------------------------------
  requestPort #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits))
    requestPort_i (
      .clock, .resetN, .req, .ack, .action, .array, .index, .in,
      .request     (heapRequest_i.source),
      .resultValid, .resultValue, .resultError,
      .out, .error
    );

  heapCheck #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits))
    heapCheck_i (
      .clock, .resetN,
      .request (heapRequest_i.sink),
      .access  (heapAccess_i.source)
    );

  elementStore #(.ArrayBits(ArrayBits), .IndexBits(IndexBits), .DataBits(DataBits))
    elementStore_i (
      .clock, .resetN,
      .access      (heapAccess_i.sink),
      .resultValid, .resultValue, .resultError
    );

endmodule

//--- verilog/elementStore.sv
// Element memory of the heap
// Read, write and add path with the registered result

module elementStore #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
) (
  input  logic                clock,
  input  logic                resetN,
  heapAccessIf.sink           access,       // Checked access
  output logic                resultValid,  // One cycle pulse
  output logic [DataBits-1:0] resultValue,
  output heapPkg::heapError_t resultError
);
  import heapPkg::*;

  localparam int AddressBits = ArrayBits + IndexBits;  // Array number above slot

  logic [DataBits-1:0]    memory [1 << AddressBits];  // All arrays side by side
  logic [AddressBits-1:0] address;
  logic [DataBits-1:0]    stored;      // Current element
  logic [DataBits-1:0]    sum;         // Wraps at DataBits
  logic [DataBits-1:0]    result;
  logic [DataBits-1:0]    storeValue;
  logic                   doStore;

  assign address = {access.array, access.slot};
  assign stored  = memory[address];
  assign sum     = stored + access.data;

  // ----------------------------------------
  // Action decode
  // ----------------------------------------
  always_comb begin
    result     = access.data;  // Alloc Size Free answer already in data
    storeValue = access.data;
    doStore    = 1'b0;
    case (access.action)
      actWrite, actPush: doStore = 1'b1;  // Echo the stored value
      actRead, actPop: result = stored;
      actAdd: begin
        result     = sum;  // New value
        storeValue = sum;
        doStore    = 1'b1;
      end
      default: result = access.data;
    endcase
    if (access.error != errNone) begin
      result  = '0;  // Failed request leaves memory alone
      doStore = 1'b0;
    end
  end

  // ----------------------------------------
  // Memory and result registers
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (access.valid && doStore) begin
      memory[address] <= storeValue;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= access.valid;  // One stage of delay
    end
  end

  always_ff @(posedge clock) begin
    if (access.valid) begin
      resultValue <= result;
      resultError <= access.error;  // Verdict passes through
    end
  end

endmodule

//--- verilog/heapCheck.sv
// Allocation bookkeeping and request validation
// Holds allocation flags, sizes and the freed-array stack
// Picks the slot and the precomputed answer for the element store

module heapCheck #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
) (
  input  logic         clock,
  input  logic         resetN,
  heapRequestIf.sink   request,  // Captured request
  heapAccessIf.source  access    // Checked access
);
  import heapPkg::*;

  localparam int ArrayCount  = 1 << ArrayBits;  // Arrays in the heap
  localparam int ArrayLength = 1 << IndexBits;  // Elements per array

  logic [ArrayCount-1:0] allocated;                     // Live arrays
  logic [IndexBits:0]    sizes      [ArrayCount];       // Element count per array
  logic [ArrayBits-1:0]  freedStack [ArrayCount];       // Most recently freed on top
  logic [ArrayBits:0]    freedTop;                      // Entries on the stack
  logic [ArrayBits:0]    neverUsed;                     // Fresh arrays left

  logic [IndexBits:0]    currentSize;  // Size of the addressed array
  logic [IndexBits:0]    wideIndex;    // Index widened for size compares
  logic                  isAllocated;
  logic [ArrayBits:0]    stackBelow;   // Top entry position
  logic [ArrayBits-1:0]  freshArray;   // Next never used array
  heapError_t            checkError;
  logic [ArrayBits-1:0]  checkArray;
  logic [IndexBits-1:0]  checkSlot;
  logic [DataBits-1:0]   checkData;
  logic                  commit;       // Request passes and updates state

  assign currentSize = sizes[request.array];
  assign wideIndex   = {1'b0, request.index};
  assign isAllocated = allocated[request.array];
  assign stackBelow  = freedTop - 1'b1;
  assign freshArray  = ArrayBits'(ArrayCount - int'(neverUsed));
  assign commit      = request.valid && (checkError == errNone);

  // ----------------------------------------
  // Validation and slot selection
  // ----------------------------------------
  always_comb begin
    checkError = errNone;
    checkArray = request.array;
    checkSlot  = request.index;
    checkData  = request.data;
    case (request.action)
      actAlloc: begin
        if (freedTop != '0) checkArray = freedStack[stackBelow[ArrayBits-1:0]];
        else if (neverUsed != '0) checkArray = freshArray;  // Only when nothing was freed
        else checkError = errOutOfMemory;
        checkData = DataBits'(checkArray);  // Answer is the array number
      end
      actFree: begin
        if (!isAllocated) checkError = errNotAllocated;  // Catches double free
        checkData = '0;
      end
      actWrite: begin
        if (!isAllocated) checkError = errNotAllocated;
        else if (wideIndex > currentSize) checkError = errOutOfBounds;  // No gaps
      end
      actRead, actAdd: begin
        if (!isAllocated) checkError = errNotAllocated;
        else if (wideIndex >= currentSize) checkError = errOutOfBounds;
      end
      actSize: begin
        if (!isAllocated) checkError = errNotAllocated;
        checkData = DataBits'(currentSize);
      end
      actPush: begin
        if (!isAllocated) checkError = errNotAllocated;
        else if (currentSize == (IndexBits+1)'(ArrayLength)) checkError = errFull;
        checkSlot = currentSize[IndexBits-1:0];  // Append after the last element
      end
      actPop: begin
        if (!isAllocated) checkError = errNotAllocated;
        else if (currentSize == '0) checkError = errEmpty;
        checkSlot = IndexBits'(currentSize - 1'b1);  // Last element
      end
      default: checkData = '0;  // Unknown action does nothing
    endcase
  end

  // ----------------------------------------
  // Heap state
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      access.valid <= 1'b0;
      allocated    <= '0;
      sizes        <= '{default: '0};
      freedTop     <= '0;
      neverUsed    <= (ArrayBits+1)'(ArrayCount);
    end else begin
      access.valid <= request.valid;  // One stage of delay
      if (commit) begin
        case (request.action)
          actAlloc: begin
            allocated[checkArray] <= 1'b1;
            sizes[checkArray]     <= '0;  // New array starts empty
            if (freedTop != '0) freedTop <= stackBelow;
            else neverUsed <= neverUsed - 1'b1;
          end
          actFree: begin
            allocated[request.array] <= 1'b0;
            freedTop                 <= freedTop + 1'b1;
          end
          actWrite: begin
            if (wideIndex == currentSize) sizes[request.array] <= currentSize + 1'b1;
          end
          actPush: sizes[request.array] <= currentSize + 1'b1;
          actPop:  sizes[request.array] <= currentSize - 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Freed stack push
  always_ff @(posedge clock) begin
    if (commit && request.action == actFree) begin
      freedStack[freedTop[ArrayBits-1:0]] <= request.array;
    end
  end

  // Access payload
  always_ff @(posedge clock) begin
    if (request.valid) begin
      access.action <= request.action;
      access.array  <= checkArray;
      access.slot   <= checkSlot;
      access.data   <= checkData;
      access.error  <= checkError;
    end
  end

endmodule

//--- verilog/heapInterfaces.sv
// Stage to stage links of the heap pipeline
// heapRequestIf carries a captured request into the checker
// heapAccessIf carries a checked access into the element store

// ----------------------------------------
// Request port to checker
// ----------------------------------------
interface heapRequestIf #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
);
  import heapPkg::*;

  logic                 valid;   // One cycle pulse per request
  heapAction_t          action;  // Operation to perform
  logic [ArrayBits-1:0] array;   // Target array
  logic [IndexBits-1:0] index;   // Element index
  logic [DataBits-1:0]  data;    // Operand

  modport source (output valid, action, array, index, data);
  modport sink   (input  valid, action, array, index, data);

endinterface

// ----------------------------------------
// Checker to element store
// ----------------------------------------
interface heapAccessIf #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
);
  import heapPkg::*;

  logic                 valid;   // One cycle pulse per checked request
  heapAction_t          action;  // Operation passed along
  logic [ArrayBits-1:0] array;   // Resolved array number
  logic [IndexBits-1:0] slot;    // Element address inside the array
  logic [DataBits-1:0]  data;    // Operand or precomputed answer
  heapError_t           error;   // Verdict of the checker

  modport source (output valid, action, array, slot, data, error);
  modport sink   (input  valid, action, array, slot, data, error);

endinterface

//--- verilog/heapPkg.sv
// Shared definitions for the array heap
// Action and error enumerations plus default widths

package heapPkg;

  // ----------------------------------------
  // Default widths
  // ----------------------------------------
  parameter int defaultArrayBits = 2;   // Number of arrays is 2**ArrayBits
  parameter int defaultIndexBits = 3;   // Elements per array is 2**IndexBits
  parameter int defaultDataBits  = 16;  // Element width

  // ----------------------------------------
  // Requested operation
  // ----------------------------------------
  typedef enum logic [3:0] {
    actAlloc = 4'd0,  // Take a freed or fresh array
    actFree  = 4'd1,  // Return an array to the heap
    actWrite = 4'd2,  // Store at index up to the size
    actRead  = 4'd3,  // Fetch below the size
    actSize  = 4'd4,  // Current element count
    actPush  = 4'd5,  // Append at the end
    actPop   = 4'd6,  // Remove from the end
    actAdd   = 4'd7   // Add in place and return new value
  } heapAction_t;

  // ----------------------------------------
  // Verdict of a request
  // ----------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,  // Request carried out
    errNotAllocated = 3'd1,  // Array not currently allocated
    errOutOfBounds  = 3'd2,  // Index beyond what the size allows
    errFull         = 3'd3,  // Push on a full array
    errEmpty        = 3'd4,  // Pop on an empty array
    errOutOfMemory  = 3'd5   // No array left to allocate
  } heapError_t;

  // Undefined action codes are served as no-ops with a zero result

endpackage

//--- verilog/requestPort.sv
// Four-phase req/ack front end of the heap
// Captures a request, waits for the result and holds it on out and error

module requestPort #(
  parameter int ArrayBits = heapPkg::defaultArrayBits,
  parameter int IndexBits = heapPkg::defaultIndexBits,
  parameter int DataBits  = heapPkg::defaultDataBits
) (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 req,          // Request strobe from the requester
  output logic                 ack,          // Result valid strobe
  input  heapPkg::heapAction_t action,       // Operation
  input  logic [ArrayBits-1:0] array,        // Target array
  input  logic [IndexBits-1:0] index,        // Element index
  input  logic [DataBits-1:0]  in,           // Operand
  heapRequestIf.source         request,      // Into the checker
  input  logic                 resultValid,  // Pulse from the element store
  input  logic [DataBits-1:0]  resultValue,
  input  heapPkg::heapError_t  resultError,
  output logic [DataBits-1:0]  out,          // Held result
  output heapPkg::heapError_t  error         // Held verdict
);
  import heapPkg::*;

  typedef enum logic [1:0] {
    phaseIdle,          // Waiting for req
    phaseBusy,          // Request in the pipeline
    phaseAcknowledged,  // ack high until req drops
    phaseRelease        // Lower ack
  } requestPhase_t;

  requestPhase_t phase;
  logic          accept;  // New request taken this cycle

  assign accept = (phase == phaseIdle) && req;

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      phase         <= phaseIdle;
      request.valid <= 1'b0;
      ack           <= 1'b0;
      out           <= '0;
      error         <= errNone;
    end else begin
      request.valid <= accept;  // Single cycle pulse
      case (phase)
        phaseIdle: begin
          if (req) phase <= phaseBusy;
        end
        phaseBusy: begin
          if (resultValid) begin
            out   <= resultValue;  // Held until the next result
            error <= resultError;
            ack   <= 1'b1;
            phase <= phaseAcknowledged;
          end
        end
        phaseAcknowledged: begin
          if (!req) phase <= phaseRelease;  // Requester saw ack
        end
        phaseRelease: begin
          ack   <= 1'b0;  // Falls a cycle after req low
          phase <= phaseIdle;
        end
        default: phase <= phaseIdle;
      endcase
    end
  end

  // ----------------------------------------
  // Request capture
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      request.action <= action;  // Inputs are stable while req is high
      request.array  <= array;
      request.index  <= index;
      request.data   <= in;
    end
  end

endmodule
